//--- hdl/ahbMemPkg.sv
// Shared bus width, address map, transfer codes and AHB-Lite structs, imported by every RTL block

package ahbMemPkg;

  ////////////////////////////////////////////////////////////////////////////
  // Bus geometry and address map
  ////////////////////////////////////////////////////////////////////////////

  // Data bus width in bits, one 64-bit word per beat
  localparam int XLEN = 64;

  // Large RAM region, 64 KiB starting at the usual RISC-V DRAM base
  localparam logic [31:0] RAM0_BASE  = 32'h8000_0000;
  localparam logic [31:0] RAM0_RANGE = 32'h0001_0000;

  // Scratch RAM region, 4 KiB
  localparam logic [31:0] RAM1_BASE  = 32'h1000_0000;
  localparam logic [31:0] RAM1_RANGE = 32'h0000_1000;

  ////////////////////////////////////////////////////////////////////////////
  // AHB-Lite transfer types
  ////////////////////////////////////////////////////////////////////////////

  // IDLE and BUSY carry no data phase, NONSEQ and SEQ start one
  localparam logic [1:0] HTRANS_IDLE   = 2'b00;
  localparam logic [1:0] HTRANS_BUSY   = 2'b01;
  localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
  localparam logic [1:0] HTRANS_SEQ    = 2'b11;

  ////////////////////////////////////////////////////////////////////////////
  // Bus structs
  ////////////////////////////////////////////////////////////////////////////

  // Address phase as driven by the master
  // The master keeps it stable for as long as HREADY is low
  typedef struct packed {
    logic [31:0] haddr;
    logic        hwrite;
    logic [1:0]  htrans;
  } ahbAddrPhase;

  // Data phase response of one slave back to the decoder
  // hresp low is OKAY and high is ERROR
  typedef struct packed {
    logic [XLEN-1:0] hrdata;
    logic            hreadyout;
    logic            hresp;
  } ahbSlaveResp;

endpackage

//--- hdl/bram1p1rw.sv
// Single-ported synchronous RAM with byte write enables, instantiated as the storage array of ahbRam
`timescale 1ns/10ps

module bram1p1rw #(
  parameter int NUM_LANES  = 8,
  parameter int ADDR_WIDTH = 10
) (
  input  logic                     HCLK,
  input  logic                     we,
  input  logic [NUM_LANES-1:0]     bwe,
  input  logic [ADDR_WIDTH-1:0]    addr,
  input  logic [NUM_LANES*8-1:0]   din,
  output logic [NUM_LANES*8-1:0]   dout
);

  // Number of words follows directly from the address width
  localparam int DEPTH = 2 ** ADDR_WIDTH;

  // Storage array, one word per entry and eight bits per lane
  logic [NUM_LANES*8-1:0] mem [DEPTH];

  ////////////////////////////////////////////////////////////////////////////
  // Write port
  ////////////////////////////////////////////////////////////////////////////

  // Each lane is written on its own so that partial stores leave
  // the untouched bytes of the word as they were
  always_ff @(posedge HCLK) begin
    for (int lane = 0; lane < NUM_LANES; lane++) begin
      if (we && bwe[lane]) begin
        mem[addr][lane*8 +: 8] <= din[lane*8 +: 8];
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read port
  ////////////////////////////////////////////////////////////////////////////

  // The word at addr is registered on every edge
  // During a write the nonblocking update means the old contents come out
  // (read-first behaviour)
  always_ff @(posedge HCLK) begin
    dout <= mem[addr];
  end

  // Note that the output register has no enable
  // The AHB wrapper steers addr so that dout is right in the cycle it is used

endmodule

//--- hdl/ahbRam.sv
// AHB-Lite slave wrapping a single-ported RAM, instantiated once per memory region by the top level
`timescale 1ns/10ps

module ahbRam #(
  parameter int unsigned RANGE = 65536
) (
  input  logic                          HCLK,
  input  logic                          rstN,
  input  logic                          hsel,
  input  ahbMemPkg::ahbAddrPhase        addrPhase,
  input  logic                          HREADY,
  input  logic [ahbMemPkg::XLEN-1:0]    HWDATA,
  input  logic [ahbMemPkg::XLEN/8-1:0]  HWSTRB,
  output ahbMemPkg::ahbSlaveResp        resp
);

  import ahbMemPkg::*;

  // Byte offset bits inside one bus word
  localparam int OFFSET     = $clog2(XLEN / 8);
  // Word index width for a region of RANGE bytes
  localparam int ADDR_WIDTH = $clog2(RANGE / (XLEN / 8));

  logic                  initTrans;
  logic                  memWrite;
  logic                  memRead;
  logic                  memWriteD;
  logic [ADDR_WIDTH-1:0] wordAddr;
  logic [ADDR_WIDTH-1:0] wordAddrD;
  logic [ADDR_WIDTH-1:0] ramAddr;
  logic                  nextReady;
  logic                  readyQ;
  logic [XLEN-1:0]       rdData;

  ////////////////////////////////////////////////////////////////////////////
  // Address phase capture
  ////////////////////////////////////////////////////////////////////////////

  // A transfer starts when the previous data phase ends, this slave is
  // selected and the master asks for a NONSEQ or SEQ beat
  assign initTrans = HREADY & hsel &
                     ((addrPhase.htrans == HTRANS_NONSEQ) |
                      (addrPhase.htrans == HTRANS_SEQ));
  assign memWrite  = initTrans & addrPhase.hwrite;
  assign memRead   = initTrans & ~addrPhase.hwrite;

  // Word index of the live address phase
  assign wordAddr = addrPhase.haddr[ADDR_WIDTH+OFFSET-1:OFFSET];

  // The write flag is control state and comes out of reset cleared,
  // so no RAM write is pending after reset
  always_ff @(posedge HCLK or negedge rstN) begin
    if (!rstN) begin
      memWriteD <= 1'b0;
    end else if (HREADY) begin
      memWriteD <= memWrite;
    end
  end

  // Delayed address for the data phase, frozen while the bus stalls
  always_ff @(posedge HCLK) begin
    if (HREADY) begin
      wordAddrD <= wordAddr;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read-after-write wait state
  ////////////////////////////////////////////////////////////////////////////

  // The single port is busy with the pending write on the edge where a
  // read is accepted, so that read needs one extra cycle
  assign nextReady = ~(memWriteD & memRead);

  always_ff @(posedge HCLK or negedge rstN) begin
    if (!rstN) begin
      readyQ <= 1'b1;
    end else begin
      readyQ <= nextReady;
    end
  end

  // Write data phases and stalls use the delayed address
  // This keeps the address aligned with HWDATA, or holds a stalled read
  assign ramAddr = (memWriteD | ~HREADY) ? wordAddrD : wordAddr;

  bram1p1rw #(
    .NUM_LANES  (XLEN / 8),
    .ADDR_WIDTH (ADDR_WIDTH)
  ) memory (
    .HCLK (HCLK),
    .we   (memWriteD),
    .bwe  (HWSTRB),
    .addr (ramAddr),
    .din  (HWDATA),
    .dout (rdData)
  );

  // The RAM never signals an error
  assign resp = '{hrdata: rdData, hreadyout: readyQ, hresp: 1'b0};

endmodule

//--- hdl/ahbDecoder.sv
// Address decoder, data-phase response mux and default ERROR slave, instantiated once in the top level
`timescale 1ns/10ps

module ahbDecoder (
  input  logic                          HCLK,
  input  logic                          rstN,
  input  ahbMemPkg::ahbAddrPhase        addrPhase,
  input  logic                          HREADY,
  input  ahbMemPkg::ahbSlaveResp        ram0Resp,
  input  ahbMemPkg::ahbSlaveResp        ram1Resp,
  output logic                          ram0Sel,
  output logic                          ram1Sel,
  output logic [ahbMemPkg::XLEN-1:0]    HRDATA,
  output logic                          HREADYOUT,
  output logic                          HRESP
);

  import ahbMemPkg::*;

  logic        xferActive;
  logic        defHit;
  logic        ownRam0;
  logic        ownRam1;
  logic        defPending;
  logic        errState;
  ahbSlaveResp defResp;
  ahbSlaveResp selResp;

  ////////////////////////////////////////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////////////////////////////////////////

  // Selects come from the address alone, as in AHB-Lite
  // The slaves check htrans themselves
  assign ram0Sel = (addrPhase.haddr >= RAM0_BASE) &&
                   (addrPhase.haddr < RAM0_BASE + RAM0_RANGE);
  assign ram1Sel = (addrPhase.haddr >= RAM1_BASE) &&
                   (addrPhase.haddr < RAM1_BASE + RAM1_RANGE);

  // Only NONSEQ and SEQ carry a data phase the default slave must fail
  always_comb begin
    case (addrPhase.htrans)
      HTRANS_NONSEQ, HTRANS_SEQ: xferActive = 1'b1;
      HTRANS_IDLE, HTRANS_BUSY:  xferActive = 1'b0;
    endcase
  end

  // An active transfer outside both regions goes to the default slave
  assign defHit = xferActive & ~ram0Sel & ~ram1Sel;

  ////////////////////////////////////////////////////////////////////////////
  // Data phase ownership and ERROR sequencer
  ////////////////////////////////////////////////////////////////////////////

  // Owner flags advance with HREADY, like every address-phase register
  // With all flags clear the default slave is idle and answers ready and OKAY
  always_ff @(posedge HCLK or negedge rstN) begin
    if (!rstN) begin
      ownRam0    <= 1'b0;
      ownRam1    <= 1'b0;
      defPending <= 1'b0;
    end else if (HREADY) begin
      ownRam0    <= ram0Sel;
      ownRam1    <= ram1Sel;
      defPending <= defHit;
    end
  end

  // Two states for a failing transfer
  // errState low is the wait cycle, high is the closing cycle
  always_ff @(posedge HCLK or negedge rstN) begin
    if (!rstN) begin
      errState <= 1'b0;
    end else begin
      errState <= defPending & ~errState;
    end
  end

  // ERROR needs HRESP high for two cycles with HREADY low in the first
  assign defResp = '{hrdata: '0, hreadyout: ~defPending | errState, hresp: defPending};

  ////////////////////////////////////////////////////////////////////////////
  // Response mux
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    if (ownRam0) begin
      selResp = ram0Resp;
    end else if (ownRam1) begin
      selResp = ram1Resp;
    end else begin
      selResp = defResp;
    end
  end

  assign HRDATA    = selResp.hrdata;
  assign HREADYOUT = selResp.hreadyout;
  assign HRESP     = selResp.hresp;

endmodule

//--- hdl/ahbMemSubsys.sv
// Top level of the AHB-Lite memory block, joining the decoder with the main and scratch RAMs
`timescale 1ns/10ps

module ahbMemSubsys (
  input  logic                          HCLK,
  input  logic                          rstN,
  input  ahbMemPkg::ahbAddrPhase        addrPhase,
  input  logic [ahbMemPkg::XLEN-1:0]    HWDATA,
  input  logic [ahbMemPkg::XLEN/8-1:0]  HWSTRB,
  output logic [ahbMemPkg::XLEN-1:0]    HRDATA,
  output logic                          HREADY,
  output logic                          HRESP
);

  import ahbMemPkg::*;

  // Per-slave selects from the decoder
  logic        ram0Sel;
  logic        ram1Sel;
  // Per-slave data phase responses back to the decoder
  ahbSlaveResp ram0Resp;
  ahbSlaveResp ram1Resp;

  ////////////////////////////////////////////////////////////////////////////
  // Decoder and default slave
  ////////////////////////////////////////////////////////////////////////////

  // HREADY leaves the decoder and comes straight back as the shared ready
  ahbDecoder decoder (
    .HCLK      (HCLK),
    .rstN      (rstN),
    .addrPhase (addrPhase),
    .HREADY    (HREADY),
    .ram0Resp  (ram0Resp),
    .ram1Resp  (ram1Resp),
    .ram0Sel   (ram0Sel),
    .ram1Sel   (ram1Sel),
    .HRDATA    (HRDATA),
    .HREADYOUT (HREADY),
    .HRESP     (HRESP)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Memory regions
  ////////////////////////////////////////////////////////////////////////////

  // Main RAM
  ahbRam #(.RANGE(RAM0_RANGE)) ram0 (
    .HCLK (HCLK), .rstN (rstN), .hsel (ram0Sel), .addrPhase (addrPhase),
    .HREADY (HREADY), .HWDATA (HWDATA), .HWSTRB (HWSTRB), .resp (ram0Resp)
  );

  // Scratch RAM, same slave logic with a smaller array
  ahbRam #(.RANGE(RAM1_RANGE)) ram1 (
    .HCLK (HCLK), .rstN (rstN), .hsel (ram1Sel), .addrPhase (addrPhase),
    .HREADY (HREADY), .HWDATA (HWDATA), .HWSTRB (HWSTRB), .resp (ram1Resp)
  );

endmodule

//--- tb/ahbMemSubsys_checker.sv
// Concurrent protocol assertions on the bus outputs, attached to the memory block top level by bind
`timescale 1ns/10ps

module ahbMemSubsysChecker (
  input logic HCLK,
  input logic rstN,
  input logic HREADY,
  input logic HRESP
);

  // Number of failed assertions, read by the testbench for its closing report
  int assertFails = 0;

  ////////////////////////////////////////////////////////////////////////////
  // Reset state
  ////////////////////////////////////////////////////////////////////////////

  // The default slave owns the data phase after reset and answers ready and OKAY
  resetIdle: assert property (@(posedge HCLK) $rose(rstN) |-> (HREADY && !HRESP))
    else begin
      assertFails++;
      $error("Bus is not ready and OKAY in the first cycle after reset");
    end

  ////////////////////////////////////////////////////////////////////////////
  // Response sequencing
  ////////////////////////////////////////////////////////////////////////////

  // An ERROR response takes two cycles
  // The first one with HREADY low must be followed by the closing one
  errorClose: assert property (@(posedge HCLK) disable iff (!rstN)
    (!HREADY && HRESP) |=> (HREADY && HRESP))
    else begin
      assertFails++;
      $error("ERROR response did not close with HREADY high and HRESP high");
    end

  // A RAM wait state never lasts more than one cycle
  waitLength: assert property (@(posedge HCLK) disable iff (!rstN)
    (!HREADY && !HRESP) |=> HREADY)
    else begin
      assertFails++;
      $error("OKAY wait state lasted longer than one cycle");
    end

endmodule

bind ahbMemSubsys ahbMemSubsysChecker protocolChecks (
  .HCLK   (HCLK),
  .rstN   (rstN),
  .HREADY (HREADY),
  .HRESP  (HRESP)
);

//--- tb/ahbMemTb.sv
// Testbench for the AHB-Lite memory block, driving directed and LFSR transfers against a shadow model
`timescale 1ns/10ps

module ahbMemTb;

  import ahbMemPkg::*;

  localparam logic [31:0] LFSR_TAPS     = 32'h8020_0003;
  localparam logic [31:0] LFSR_SEED     = 32'h0012_ab9c;
  localparam logic [31:0] UNMAPPED_BASE = 32'h4000_0000;

  // One accepted address phase, kept until its data phase ends
  // region is 0 for ram0, 1 for ram1 and 2 for the unmapped area
  typedef struct packed {
    logic              valid;
    logic              write;
    logic [1:0]        region;
    logic [31:0]       addr;
    logic [XLEN-1:0]   wdata;
    logic [XLEN/8-1:0] strb;
    logic [1:0]        expWaits;
  } xferRecord;

  logic              HCLK;
  logic              rstN;
  ahbAddrPhase       addrPhase;
  logic [XLEN-1:0]   HWDATA;
  logic [XLEN/8-1:0] HWSTRB;
  logic [XLEN-1:0]   HRDATA;
  logic              HREADY;
  logic              HRESP;

  xferRecord   pending;
  string       pendName;
  logic [1:0]  lastWriteRegion;
  logic [31:0] lfsrState;
  int          dataErrors;
  int          respErrors;
  int          waitErrors;
  int          cycleCount;
  int          budget;

  // Shadow copies of both regions, with a flag per byte once it holds a known value
  logic [7:0] shadow0 [RAM0_RANGE];
  bit         known0  [RAM0_RANGE];
  logic [7:0] shadow1 [RAM1_RANGE];
  bit         known1  [RAM1_RANGE];

  ahbMemSubsys ahbMemSubsys_inst (
    .HCLK (HCLK), .rstN (rstN), .addrPhase (addrPhase), .HWDATA (HWDATA),
    .HWSTRB (HWSTRB), .HRDATA (HRDATA), .HREADY (HREADY), .HRESP (HRESP)
  );

  always #2 HCLK = ~HCLK;

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus source and reference model
  ////////////////////////////////////////////////////////////////////////////

  // Galois LFSR, one step per bit handed out
  function automatic logic [63:0] randomBits(input int n);
    logic [63:0] value;
    logic        outBit;
    value = '0;
    for (int i = 0; i < n; i++) begin
      outBit    = lfsrState[0];
      lfsrState = lfsrState >> 1;
      if (outBit) lfsrState = lfsrState ^ LFSR_TAPS;
      value = {value[62:0], outBit};
    end
    return value;
  endfunction

  function automatic logic [1:0] regionOf(input logic [31:0] addr);
    if (addr >= RAM0_BASE && addr < RAM0_BASE + RAM0_RANGE) return 2'd0;
    if (addr >= RAM1_BASE && addr < RAM1_BASE + RAM1_RANGE) return 2'd1;
    return 2'd2;
  endfunction

  // Both bases are aligned to their size, so the low address bits are the offset
  function automatic void applyWrite(input xferRecord rec);
    logic [31:0] byteAddr;
    for (int lane = 0; lane < XLEN / 8; lane++) begin
      byteAddr = rec.addr + 32'(lane);
      if (rec.strb[lane] && rec.region == 2'd0) begin
        shadow0[byteAddr[15:0]] = rec.wdata[lane*8 +: 8];
        known0[byteAddr[15:0]]  = 1'b1;
      end else if (rec.strb[lane] && rec.region == 2'd1) begin
        shadow1[byteAddr[11:0]] = rec.wdata[lane*8 +: 8];
        known1[byteAddr[11:0]]  = 1'b1;
      end
    end
  endfunction

  // Bytes never written have no expected value and are masked out
  task automatic predictRead(input xferRecord rec, output logic [XLEN-1:0] data,
                             output logic [XLEN-1:0] mask);
    logic [31:0] byteAddr;
    data = '0;
    mask = '0;
    for (int lane = 0; lane < XLEN / 8; lane++) begin
      byteAddr = rec.addr + 32'(lane);
      if (rec.region == 2'd0 && known0[byteAddr[15:0]]) begin
        data[lane*8 +: 8] = shadow0[byteAddr[15:0]];
        mask[lane*8 +: 8] = 8'hff;
      end else if (rec.region == 2'd1 && known1[byteAddr[11:0]]) begin
        data[lane*8 +: 8] = shadow1[byteAddr[11:0]];
        mask[lane*8 +: 8] = 8'hff;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Bus driver and data phase checks
  ////////////////////////////////////////////////////////////////////////////

  // Called at the falling edge just before the edge that ends the data phase
  task automatic checkDataPhase(input int waits);
    logic [XLEN-1:0] expData;
    logic [XLEN-1:0] mask;
    logic            expResp;
    expResp = pending.valid && (pending.region == 2'd2);
    assert (HRESP == expResp) else begin
      $display("CHECK FAILED %s hresp at 0x%08h: expected %0d actual %0d",
               pendName, pending.addr, expResp, HRESP);
      respErrors++;
    end
    assert (waits == int'(pending.expWaits)) else begin
      $display("CHECK FAILED %s wait states at 0x%08h: expected %0d actual %0d",
               pendName, pending.addr, pending.expWaits, waits);
      waitErrors++;
    end
    if (pending.valid && pending.region != 2'd2) begin
      if (pending.write) begin
        applyWrite(pending);
      end else begin
        predictRead(pending, expData, mask);
        assert (((HRDATA ^ expData) & mask) == '0) else begin
          $display("CHECK FAILED %s read at 0x%08h: expected 0x%016h actual 0x%016h",
                   pendName, pending.addr, expData, HRDATA & mask);
          dataErrors++;
        end
      end
    end
  endtask

  // Drives one address phase at a falling edge and returns at the falling edge
  // after it was accepted, with HWDATA and HWSTRB set for its data phase
  task automatic runTransfer(input logic active, input logic write, input logic [31:0] addr,
                             input logic [XLEN-1:0] wdata, input logic [XLEN/8-1:0] strb,
                             input string name);
    xferRecord accepted;
    int        waits;
    logic      waitResp;
    budget += 2;
    addrPhase = '{haddr: addr, hwrite: write, htrans: active ? HTRANS_NONSEQ : HTRANS_IDLE};
    waits = 0;
    // An ERROR response holds HRESP high in its wait cycle too, while a RAM wait keeps it low
    waitResp = pending.valid && (pending.region == 2'd2);
    while (!HREADY) begin
      assert (HRESP == waitResp) else begin
        $display("CHECK FAILED %s hresp in wait state at 0x%08h: expected %0d actual %0d",
                 pendName, pending.addr, waitResp, HRESP);
        respErrors++;
      end
      @(negedge HCLK);
      waits++;
    end
    checkDataPhase(waits);
    accepted = '{valid: active, write: write, region: regionOf(addr), addr: addr,
                 wdata: wdata, strb: strb, expWaits: 2'd0};
    // Unmapped transfers wait once, and so does a read right behind a write to its RAM
    if (active && accepted.region == 2'd2) accepted.expWaits = 2'd1;
    if (active && !write && accepted.region == lastWriteRegion) accepted.expWaits = 2'd1;
    lastWriteRegion = (active && write) ? accepted.region : 2'd3;
    @(negedge HCLK);
    pending  = accepted;
    pendName = name;
    HWDATA   = wdata;
    HWSTRB   = strb;
  endtask

  task automatic writeWord(input logic [31:0] addr, input logic [XLEN-1:0] data,
                           input logic [XLEN/8-1:0] strb, input string name);
    runTransfer(1'b1, 1'b1, addr, data, strb, name);
  endtask

  task automatic readWord(input logic [31:0] addr, input string name);
    runTransfer(1'b1, 1'b0, addr, '0, '0, name);
  endtask

  task automatic idleCycles(input int n, input string name);
    repeat (n) runTransfer(1'b0, 1'b0, 32'h0, '0, '0, name);
  endtask

  task automatic reportCounts();
    $display("Errors: data %0d, response %0d, wait %0d, protocol %0d", dataErrors,
             respErrors, waitErrors, ahbMemSubsys_inst.protocolChecks.assertFails);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Watchdog
  ////////////////////////////////////////////////////////////////////////////

  // Each issued transfer adds its worst case of two data phase cycles to the budget
  initial begin
    cycleCount = 0;
    budget     = 0;
    while (cycleCount <= 2 * budget + 50) begin
      @(posedge HCLK);
      cycleCount++;
    end
    $display("Run stopped after %0d cycles because the bus stopped completing transfers",
             cycleCount);
    reportCounts();
    $display(">>> FAIL");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [63:0] r;
    logic [63:0] s;
    logic [63:0] kind;
    logic [63:0] sel;
    logic [63:0] word;
    logic [31:0] base;
    logic [31:0] addr;
    int          totalErrors;
    HCLK            = 1'b0;
    rstN            = 1'b0;
    addrPhase       = '{haddr: 32'h0, hwrite: 1'b0, htrans: HTRANS_IDLE};
    HWDATA          = '0;
    HWSTRB          = '0;
    pending         = '0;
    pendName        = "reset";
    lastWriteRegion = 2'd3;
    lfsrState       = LFSR_SEED;
    dataErrors      = 0;
    respErrors      = 0;
    waitErrors      = 0;
    repeat (2) @(posedge HCLK);
    @(negedge HCLK);
    rstN = 1'b1;

    // Idle bus after reset stays ready and OKAY
    idleCycles(4, "reset idle");

    // Full words in both regions at the same offsets, then read back
    for (int i = 0; i < 4; i++) begin
      r = randomBits(64);
      writeWord(RAM0_BASE + 32'(8 * i), r, 8'hff, "full word ram0");
      r = randomBits(64);
      writeWord(RAM1_BASE + 32'(8 * i), r, 8'hff, "full word ram1");
    end
    for (int i = 0; i < 4; i++) begin
      readWord(RAM0_BASE + 32'(8 * i), "full word ram0");
      readWord(RAM1_BASE + 32'(8 * i), "full word ram1");
    end

    // Random byte strobes over a fully written word
    for (int i = 0; i < 6; i++) begin
      base = (i % 2 == 0) ? RAM0_BASE : RAM1_BASE;
      addr = base + 32'h100 + 32'(8 * i);
      r = randomBits(64);
      writeWord(addr, r, 8'hff, "strobe setup");
      r = randomBits(64);
      s = randomBits(8);
      writeWord(addr, r, s[7:0], "strobe write");
      idleCycles(1, "strobe gap");
      readWord(addr, "strobe readback");
    end

    // Read right behind a write waits once, reads behind reads do not
    r = randomBits(64);
    writeWord(RAM0_BASE + 32'h200, r, 8'hff, "raw write ram0");
    readWord(RAM0_BASE + 32'h200, "raw read ram0");
    readWord(RAM0_BASE + 32'h200, "back to back read ram0");
    readWord(RAM0_BASE + 32'h100, "back to back read ram0");
    r = randomBits(64);
    writeWord(RAM1_BASE + 32'h208, r, 8'hff, "raw write ram1");
    readWord(RAM1_BASE + 32'h108, "raw read other word ram1");
    readWord(RAM1_BASE + 32'h208, "back to back read ram1");

    // Unmapped transfers fail and leave both RAMs untouched
    r = randomBits(64);
    writeWord(RAM0_BASE + 32'h40, r, 8'hff, "alias setup");
    r = randomBits(64);
    writeWord(RAM0_BASE + RAM0_RANGE + 32'h40, r, 8'hff, "unmapped write");
    readWord(UNMAPPED_BASE, "unmapped read");
    writeWord(RAM1_BASE + 32'h48, r, 8'hff, "write after error");
    readWord(RAM1_BASE + RAM1_RANGE, "unmapped read past ram1");
    readWord(RAM0_BASE + 32'h40, "alias check");
    readWord(RAM1_BASE + 32'h48, "readback after error");

    // Random mix over a small window per region so reads hit written words
    for (int i = 0; i < 300; i++) begin
      kind = randomBits(2);
      sel  = randomBits(3);
      word = randomBits(5);
      if (sel[2:0] == 3'd7) base = UNMAPPED_BASE;
      else if (sel[2:0] >= 3'd4) base = RAM1_BASE;
      else base = RAM0_BASE;
      addr = base + {24'h0, word[4:0], 3'b000};
      if (kind[1:0] == 2'd0) begin
        idleCycles(1, "random idle");
      end else if (kind[1:0] == 2'd1) begin
        r = randomBits(64);
        s = randomBits(8);
        writeWord(addr, r, s[7:0], "random write");
      end else begin
        readWord(addr, "random read");
      end
    end
    idleCycles(2, "final idle");

    totalErrors = dataErrors + respErrors + waitErrors +
                  ahbMemSubsys_inst.protocolChecks.assertFails;
    reportCounts();
    if (totalErrors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- src.f
hdl/ahbMemPkg.sv
hdl/bram1p1rw.sv
hdl/ahbRam.sv
hdl/ahbDecoder.sv
hdl/ahbMemSubsys.sv
tb/ahbMemSubsys_checker.sv
tb/ahbMemTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build the memory block testbench with Verilator, run it and look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module ahbMemTb -f src.f -o ahbMemSim

# The simulation may stop early on a failing assertion, so its status is not used here
simOut=$(./obj_dir/ahbMemSim || true)
echo "$simOut"

if grep -qxF '>>> PASS' <<< "$simOut"; then
  exit 0
fi
exit 1
